// File: sram_pg_settings.svh
// Power-gated SRAM settings
`ifndef SRAM_PG_SETTINGS_SVH
`define SRAM_PG_SETTINGS_SVH

// Full flat word address across all banks
`define SRAM_PG_ADDR_W 14

// Width of one stored word
`define SRAM_PG_DATA_W 21

// Banks in the array, selected by the top address bits
`define SRAM_PG_BANKS 4

// Row address inside one bank
`define SRAM_PG_BANK_ADDR_W 12

// Cycles each bank's power switch holds the chain enable before passing it on
`define SRAM_PG_SW_DELAY 2

`endif

// File: sram_pg_pkg.sv
// Power-gated SRAM types
`default_nettype none

`include "sram_pg_settings.svh"

package sram_pg_pkg;

    // One data word as stored in a bank row
    typedef logic [`SRAM_PG_DATA_W-1:0] mem_word_t;

    // The flat index seen by the requester is the same bits as the
    // bank/row pair that the array decodes
    typedef union packed {
        logic [`SRAM_PG_ADDR_W-1:0] flat;
        struct packed {
            logic [`SRAM_PG_ADDR_W-`SRAM_PG_BANK_ADDR_W-1:0] bank;
            logic [`SRAM_PG_BANK_ADDR_W-1:0]                 row;
        } field;
    } mem_addr_u;

endpackage

`default_nettype wire

// File: mem_reset_sync_scan.sv
// Reset synchronizer with scan bypass
`timescale 1ns/1ps
`default_nettype none

module mem_reset_sync_scan (
    input  logic clk,
    input  logic rst_n,
    input  logic fscan_rstbypen,
    input  logic fscan_byprst_b,
    output logic rst_n_sync
);

    logic rst_meta;
    logic rst_stable;

    // Assertion is immediate, release takes two clock edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_meta   <= 1'b0;
            rst_stable <= 1'b0;
        end else begin
            rst_meta   <= 1'b1;
            rst_stable <= rst_meta;
        end
    end

    // Scan takes direct control of the reset so the flops stay observable
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : rst_stable;

endmodule

`default_nettype wire

// File: sram_bank_model.sv
// Behavioral power-gated SRAM bank
`timescale 1ns/1ps
`default_nettype none

`include "sram_pg_settings.svh"

module sram_bank_model (
    input  logic                              clk,
    input  logic                              ip_reset_b,
    input  logic                              rd_en,
    input  logic                              wr_en,
    input  logic [`SRAM_PG_BANK_ADDR_W-1:0]   addr,
    input  sram_pg_pkg::mem_word_t            wdata,
    input  logic                              isol_en,
    input  logic                              pwr_enable_b_in,
    output sram_pg_pkg::mem_word_t            rdata,
    output logic                              pwr_enable_b_out
);

    localparam int depth = 1 << `SRAM_PG_BANK_ADDR_W;

    logic [`SRAM_PG_SW_DELAY-1:0] sw_q;
    logic [depth-1:0]             row_valid;
    logic                         powered_down;
    sram_pg_pkg::mem_word_t       mem [depth];
    sram_pg_pkg::mem_word_t       rd_q;

    // ********************
    // Power switch
    // ********************

    // The enable ripples through the switch and comes out delayed, and the
    // delayed copy is what actually gates the array supply
    always_ff @(posedge clk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            sw_q <= '1;
        end else begin
            sw_q <= {sw_q[`SRAM_PG_SW_DELAY-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = sw_q[`SRAM_PG_SW_DELAY-1];
    assign powered_down     = pwr_enable_b_out;

    // ********************
    // Array
    // ********************

    // Losing supply wipes every row, so all valid bits drop together
    always_ff @(posedge clk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            row_valid <= '0;
        end else if (powered_down) begin
            row_valid <= '0;
        end else if (wr_en) begin
            row_valid[addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!powered_down && wr_en) begin
            mem[addr] <= wdata;
        end
    end

    // Read data is held until the next read
    always_ff @(posedge clk) begin
        if (powered_down) begin
            rd_q <= '0;
        end else if (rd_en) begin
            rd_q <= row_valid[addr] ? mem[addr] : '0;
        end
    end

    // Clamp the output while the domain is isolated
    assign rdata = isol_en ? '0 : rd_q;

    // Access is only legal with the bank fully powered and connected
    a_access_powered: assert property (
        @(posedge clk) disable iff (!ip_reset_b)
        (rd_en || wr_en) |-> (!powered_down && !isol_en)
    );

endmodule

`default_nettype wire

// File: sram_pg_16384x21.sv
// Four-bank power-gated SRAM array
`timescale 1ns/1ps
`default_nettype none

`include "sram_pg_settings.svh"

module sram_pg_16384x21 (
    input  logic                    clk,
    input  logic                    clk_rst_n,
    input  logic                    ip_reset_b_sync,
    input  logic                    re,
    input  logic                    we,
    input  sram_pg_pkg::mem_addr_u  addr,
    input  sram_pg_pkg::mem_word_t  wdata,
    input  logic                    pgcb_isol_en,
    input  logic                    pwr_enable_b_in,
    output sram_pg_pkg::mem_word_t  rdata,
    output logic                    pwr_enable_b_out
);

    logic [`SRAM_PG_BANKS-1:0] bank_hit;
    logic [`SRAM_PG_BANKS-1:0] re_sel;
    logic [`SRAM_PG_BANKS-1:0] we_sel;
    logic [`SRAM_PG_BANKS-1:0] re_sel_reg;
    logic [`SRAM_PG_BANKS:0]   pwr_chain;
    sram_pg_pkg::mem_word_t    bank_rdata [`SRAM_PG_BANKS];

    // ********************
    // Bank decode
    // ********************

    always_comb begin
        for (int i = 0; i < `SRAM_PG_BANKS; i++) begin
            bank_hit[i] = (addr.field.bank == i);
        end
    end

    assign re_sel = bank_hit & {`SRAM_PG_BANKS{re}};
    assign we_sel = bank_hit & {`SRAM_PG_BANKS{we}};

    // Remember which bank the last read went to, since its data comes back
    // a cycle later
    always_ff @(posedge clk or negedge clk_rst_n) begin
        if (!clk_rst_n) begin
            re_sel_reg <= '0;
        end else if (re) begin
            re_sel_reg <= re_sel;
        end
    end

    // ********************
    // Banks and power chain
    // ********************

    assign pwr_chain[0] = pwr_enable_b_in;

    for (genvar b = 0; b < `SRAM_PG_BANKS; b++) begin : g_bank
        sram_bank_model u_bank (
            .clk              (clk),
            .ip_reset_b       (ip_reset_b_sync),
            .rd_en            (re_sel[b]),
            .wr_en            (we_sel[b]),
            .addr             (addr.field.row),
            .wdata            (wdata),
            .isol_en          (pgcb_isol_en),
            .pwr_enable_b_in  (pwr_chain[b]),
            .rdata            (bank_rdata[b]),
            .pwr_enable_b_out (pwr_chain[b+1])
        );
    end

    // Last bank closes the chain back to the controller
    assign pwr_enable_b_out = pwr_chain[`SRAM_PG_BANKS];

    // Read mux
    always_comb begin
        rdata = '0;
        for (int i = 0; i < `SRAM_PG_BANKS; i++) begin
            if (re_sel_reg[i]) begin
                rdata = bank_rdata[i];
            end
        end
    end

    a_no_rd_wr_same_cycle: assert property (
        @(posedge clk) disable iff (!clk_rst_n)
        !(re && we)
    );

    a_rd_sel_onehot: assert property (
        @(posedge clk) disable iff (!clk_rst_n)
        re |=> $onehot(re_sel_reg)
    );

endmodule

`default_nettype wire

// File: sram_pwr_gate_ctrl.sv
// SRAM power-gate sequencer
`timescale 1ns/1ps
`default_nettype none

module sram_pwr_gate_ctrl (
    input  logic clk,
    input  logic clk_rst_n,
    input  logic sleep_req,
    input  logic pwr_enable_b_ret,
    output logic pgcb_isol_en,
    output logic pwr_enable_b,
    output logic mem_ready
);

    localparam logic [2:0] st_awake         = 3'd0;
    localparam logic [2:0] st_isolating     = 3'd1;
    localparam logic [2:0] st_powering_down = 3'd2;
    localparam logic [2:0] st_asleep        = 3'd3;
    localparam logic [2:0] st_powering_up   = 3'd4;

    logic [2:0] state;

    // ********************
    // Sequencer
    // ********************

    // Reset parks the memory asleep so the normal wake sequence brings it up
    always_ff @(posedge clk or negedge clk_rst_n) begin
        if (!clk_rst_n) begin
            state        <= st_asleep;
            pgcb_isol_en <= 1'b1;
            pwr_enable_b <= 1'b1;
            mem_ready    <= 1'b0;
        end else begin
            case (state)
                st_awake: begin
                    if (sleep_req) begin
                        pgcb_isol_en <= 1'b1;
                        mem_ready    <= 1'b0;
                        state        <= st_isolating;
                    end else begin
                        // One cycle after isolation drops on the way up
                        mem_ready <= 1'b1;
                    end
                end
                st_isolating: begin
                    pwr_enable_b <= 1'b1;
                    state        <= st_powering_down;
                end
                st_powering_down: begin
                    // Every bank must be off before a wake may start
                    if (pwr_enable_b_ret) begin
                        state <= st_asleep;
                    end
                end
                st_asleep: begin
                    if (!sleep_req) begin
                        pwr_enable_b <= 1'b0;
                        state        <= st_powering_up;
                    end
                end
                st_powering_up: begin
                    if (!pwr_enable_b_ret) begin
                        pgcb_isol_en <= 1'b0;
                        state        <= st_awake;
                    end
                end
                default: begin
                    state <= st_asleep;
                end
            endcase
        end
    end

    // Ready implies the whole chain has come back and the outputs are connected
    a_ready_means_powered: assert property (
        @(posedge clk) disable iff (!clk_rst_n)
        mem_ready |-> (!pgcb_isol_en && !pwr_enable_b_ret)
    );

endmodule

`default_nettype wire

// File: sram_pg_subsys_top.sv
// Power-gated SRAM subsystem
`timescale 1ns/1ps
`default_nettype none

module sram_pg_subsys_top (
    input  logic                    clk,
    input  logic                    clk_rst_n,
    input  logic                    ip_reset_b,
    input  logic                    fscan_rstbypen,
    input  logic                    fscan_byprst_b,
    input  logic                    sleep_req,
    input  logic                    re,
    input  logic                    we,
    input  sram_pg_pkg::mem_addr_u  addr,
    input  sram_pg_pkg::mem_word_t  wdata,
    output sram_pg_pkg::mem_word_t  rdata,
    output logic                    mem_ready
);

    logic ip_reset_b_sync;
    logic pgcb_isol_en;
    logic pwr_enable_b;
    logic pwr_enable_b_ret;

    // IP reset for the banks
    mem_reset_sync_scan u_ip_reset_sync (
        .clk            (clk),
        .rst_n          (ip_reset_b),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .rst_n_sync     (ip_reset_b_sync)
    );

    sram_pwr_gate_ctrl u_pg_ctrl (
        .clk              (clk),
        .clk_rst_n        (clk_rst_n),
        .sleep_req        (sleep_req),
        .pwr_enable_b_ret (pwr_enable_b_ret),
        .pgcb_isol_en     (pgcb_isol_en),
        .pwr_enable_b     (pwr_enable_b),
        .mem_ready        (mem_ready)
    );

    sram_pg_16384x21 u_mem (
        .clk              (clk),
        .clk_rst_n        (clk_rst_n),
        .ip_reset_b_sync  (ip_reset_b_sync),
        .re               (re),
        .we               (we),
        .addr             (addr),
        .wdata            (wdata),
        .pgcb_isol_en     (pgcb_isol_en),
        .pwr_enable_b_in  (pwr_enable_b),
        .rdata            (rdata),
        .pwr_enable_b_out (pwr_enable_b_ret)
    );

endmodule

`default_nettype wire

// File: tb_sram_pg_subsys.sv
// Power-gated SRAM subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "sram_pg_settings.svh"

module tb_sram_pg_subsys;

    localparam int depth         = 1 << `SRAM_PG_ADDR_W;
    localparam int ready_timeout = 64;
    localparam int rand_writes   = 24;

    logic                   clk;
    logic                   clk_rst_n;
    logic                   ip_reset_b;
    logic                   fscan_rstbypen;
    logic                   fscan_byprst_b;
    logic                   sleep_req;
    logic                   re;
    logic                   we;
    sram_pg_pkg::mem_addr_u addr;
    sram_pg_pkg::mem_word_t wdata;
    sram_pg_pkg::mem_word_t rdata;
    logic                   mem_ready;

    // Expected contents, zero for rows not written since the last power-up
    sram_pg_pkg::mem_word_t ref_mem [depth];
    logic                   pend_valid;
    sram_pg_pkg::mem_word_t pend_exp;
    logic                   ready_seen;
    int unsigned            rng_seed;

    sram_pg_subsys_top uut (
        .clk            (clk),
        .clk_rst_n      (clk_rst_n),
        .ip_reset_b     (ip_reset_b),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .sleep_req      (sleep_req),
        .re             (re),
        .we             (we),
        .addr           (addr),
        .wdata          (wdata),
        .rdata          (rdata),
        .mem_ready      (mem_ready)
    );

    always #2 clk = ~clk;

    // ********************
    // Checks
    // ********************

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string name, input sram_pg_pkg::mem_word_t actual,
                              input sram_pg_pkg::mem_word_t expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%h, got 0x%h at %0t", name, expected, actual,
                     $time);
            stop_on_error();
        end
    endtask

    task automatic check_ready(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%h, got 0x%h at %0t", name, expected, actual,
                     $time);
            stop_on_error();
        end
    endtask

    task automatic wait_ready(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (mem_ready !== level && cycles < ready_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (mem_ready !== level) begin
            $display("Timeout: mem_ready did not reach %0b within %0d cycles", level,
                     ready_timeout);
            stop_on_error();
        end
        ready_seen = mem_ready;
    endtask

    // ********************
    // Stimulus
    // ********************

    // A read issued last cycle has its data on rdata by this falling edge
    task automatic settle_pending();
        @(negedge clk);
        if (pend_valid) begin
            check_word("rdata", rdata, pend_exp);
        end
        pend_valid = 1'b0;
        ready_seen = mem_ready;
    endtask

    task automatic run_access(input logic is_write, input logic [`SRAM_PG_ADDR_W-1:0] flat_addr,
                              input sram_pg_pkg::mem_word_t data,
                              input sram_pg_pkg::mem_word_t expected);
        @(posedge clk);
        check_ready("mem_ready", ready_seen, 1'b1);
        re        <= ~is_write;
        we        <= is_write;
        addr.flat <= flat_addr;
        wdata     <= is_write ? data : '0;
        settle_pending();
        if (is_write) begin
            ref_mem[flat_addr] = data;
        end else begin
            pend_valid = 1'b1;
            pend_exp   = expected;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        re <= 1'b0;
        we <= 1'b0;
        settle_pending();
    endtask

    task automatic clear_reference();
        for (int i = 0; i < depth; i++) begin
            ref_mem[i] = '0;
        end
    endtask

    task automatic enter_sleep(input int hold, input logic expected);
        @(posedge clk);
        re        <= 1'b0;
        we        <= 1'b0;
        sleep_req <= 1'b1;
        settle_pending();
        // Ready drops on the first edge that sees the request
        @(negedge clk);
        check_ready("mem_ready", mem_ready, expected);
        repeat (hold) @(posedge clk);
        // Every bank loses power on the way down
        clear_reference();
    endtask

    task automatic leave_sleep(input logic expected);
        @(posedge clk);
        sleep_req <= 1'b0;
        wait_ready(expected);
    endtask

    task automatic run_file();
        int                fd;
        int                n;
        logic [8*128-1:0]  line_buf;
        logic [63:0]       op_txt;
        logic [31:0]       f_addr;
        logic [31:0]       f_data;
        logic [31:0]       f_exp;
        fd = $fopen("sram_pg_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file sram_pg_testdata.txt");
            stop_on_error();
        end
        while (!$feof(fd)) begin
            line_buf = '0;
            op_txt   = '0;
            n = $fgets(line_buf, fd);
            n = $sscanf(line_buf, "%s %h %h %h", op_txt, f_addr, f_data, f_exp);
            // Comment and blank lines do not parse into four fields
            if (n == 4) begin
                if (op_txt == "W") begin
                    run_access(1'b1, f_addr[`SRAM_PG_ADDR_W-1:0], f_data[`SRAM_PG_DATA_W-1:0],
                               '0);
                end else if (op_txt == "R") begin
                    run_access(1'b0, f_addr[`SRAM_PG_ADDR_W-1:0], '0,
                               f_exp[`SRAM_PG_DATA_W-1:0]);
                end else if (op_txt == "SLEEP") begin
                    enter_sleep(int'(f_data), f_exp[0]);
                end else if (op_txt == "WAKE") begin
                    leave_sleep(f_exp[0]);
                end else begin
                    $display("Unknown operation %0s in the test data file", op_txt);
                    stop_on_error();
                end
            end
        end
        $fclose(fd);
    endtask

    // Random words at random rows, read back in order, then a few stray reads
    task automatic run_random();
        logic [`SRAM_PG_ADDR_W-1:0] rand_addrs [$];
        logic [31:0]                r;
        logic [`SRAM_PG_ADDR_W-1:0] a;
        for (int i = 0; i < rand_writes; i++) begin
            r = $urandom();
            a = r[`SRAM_PG_ADDR_W-1:0];
            r = $urandom();
            rand_addrs.push_back(a);
            run_access(1'b1, a, r[`SRAM_PG_DATA_W-1:0], '0);
        end
        foreach (rand_addrs[i]) begin
            run_access(1'b0, rand_addrs[i], '0, ref_mem[rand_addrs[i]]);
        end
        repeat (8) begin
            r = $urandom();
            a = r[`SRAM_PG_ADDR_W-1:0];
            run_access(1'b0, a, '0, ref_mem[a]);
        end
        idle_cycle();
    endtask

    initial begin
        clk            = 1'b0;
        clk_rst_n      = 1'b0;
        ip_reset_b     = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        sleep_req      = 1'b0;
        re             = 1'b0;
        we             = 1'b0;
        addr           = '0;
        wdata          = '0;
        pend_valid     = 1'b0;
        pend_exp       = '0;
        ready_seen     = 1'b0;
        clear_reference();
        rng_seed = 32'h19ca_8d31;
        void'($urandom(rng_seed));

        repeat (10) @(posedge clk);
        clk_rst_n  <= 1'b1;
        ip_reset_b <= 1'b1;
        // The controller wakes the memory by itself after reset
        wait_ready(1'b1);

        run_file();
        run_random();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
sram_pg_pkg.sv
mem_reset_sync_scan.sv
sram_bank_model.sv
sram_pg_16384x21.sv
sram_pwr_gate_ctrl.sv
sram_pg_subsys_top.sv
tb_sram_pg_subsys.sv

// File: Bender.yml
package:
  name: sram_pg_subsys

sources:
  - include_dirs:
      - .
    files:
      - sram_pg_pkg.sv
      - mem_reset_sync_scan.sv
      - sram_bank_model.sv
      - sram_pg_16384x21.sv
      - sram_pwr_gate_ctrl.sv
      - sram_pg_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sram_pg_subsys.sv

// File: sram_pg_testdata.txt
# Columns: op, flat addr (hex), data (hex), expected (hex)
# SLEEP data is hold cycles, SLEEP and WAKE expect mem_ready
W 0005 0ABCDE 000000
R 0005 000000 0ABCDE
# Same row in all four banks
W 0123 100001 000000
W 1123 0F0F0F 000000
W 2123 1FFFFF 000000
W 3123 054321 000000
R 0123 000000 100001
R 1123 000000 0F0F0F
R 2123 000000 1FFFFF
R 3123 000000 054321
# Back-to-back reads hopping between banks
R 3123 000000 054321
R 0123 000000 100001
R 2123 000000 1FFFFF
R 1123 000000 0F0F0F
# Bank boundaries
W 0FFF 000777 000000
W 3FFF 1A2B3C 000000
W 1000 000001 000000
R 0FFF 000000 000777
R 3FFF 000000 1A2B3C
R 1000 000000 000001
R 2ABC 000000 000000
SLEEP 0000 000006 000000
WAKE 0000 000000 000001
# Contents are gone after the power cycle
R 0005 000000 000000
R 0123 000000 000000
R 1123 000000 000000
R 2123 000000 000000
R 3123 000000 000000
R 3FFF 000000 000000
W 1123 0DEAD1 000000
W 3FFF 0BEEF2 000000
R 1123 000000 0DEAD1
R 3FFF 000000 0BEEF2
R 2123 000000 000000
